/* design/cmd_ctrl_macros.svh */
`ifndef CMD_CTRL_MACROS_SVH
`define CMD_CTRL_MACROS_SVH

// Command buffer depth in bytes
`define CMD_MAX_BYTES 8

// Slots in each configuration bank
`define CFG_SLOTS 16

// Number of ports
`define CFG_PORTS 4

// Width of a register address
`define REG_ADDR_BITS 6

`endif

/* design/cmd_ctrl_pkg.sv */
`include "cmd_ctrl_macros.svh"

package cmd_ctrl_pkg;

    // Command and reply ids as seen on EP4 and EP8
    typedef enum logic [7:0] {
        OP_GET_REG       = 8'h31,
        OP_SET_REG       = 8'h32,
        OP_DATA_REG      = 8'h90,
        OP_ERR_NOT_FOUND = 8'hF0
    } cmd_opcode_e;

    // Endpoint header
    // An id of zero on EP8 means no reply is pending
    typedef struct packed {
        logic [7:0]  id;
        logic [15:0] length;
    } cmd_hdr_t;

    typedef logic [`CMD_MAX_BYTES-1:0][7:0] cmd_bytes_t;

    typedef enum logic [1:0] {
        ST_WAITING,
        ST_READING,
        ST_EXECUTING,
        ST_REPLYING
    } ctrl_state_e;

    typedef enum logic {
        CFG_LOOKUP,
        CFG_STORE
    } cfg_op_e;

    typedef struct packed {
        cfg_op_e                   op;
        logic [1:0]                port;
        logic [`REG_ADDR_BITS-1:0] addr;
        logic [7:0]                value;
        logic                      dir;
        logic                      chan;
    } cfg_req_t;

    typedef enum logic [1:0] {
        CFG_HIT,
        CFG_STORED,
        CFG_MISS,
        CFG_FULL
    } cfg_status_e;

    typedef struct packed {
        cfg_status_e status;
        logic [7:0]  value;
    } cfg_result_t;

    typedef struct packed {
        logic                      used;
        logic [`REG_ADDR_BITS-1:0] addr;
        logic [7:0]                value;
    } slot_entry_t;

endpackage

/* design/ep4_reader.sv */
`timescale 1ns/1ps
`include "cmd_ctrl_macros.svh"

module ep4_reader (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  cmd_ctrl_pkg::cmd_hdr_t   ep4_hdr,
    input  logic                     ep4_ready,
    input  logic [7:0]               ep4_data,
    output logic                     ep4_read,
    output logic                     done,
    output cmd_ctrl_pkg::cmd_bytes_t cmd_bytes
);
    localparam int IDX_BITS = $clog2(`CMD_MAX_BYTES);

    typedef enum logic [1:0] {RD_IDLE, RD_ACTIVE, RD_DONE} rd_state_e;

    rd_state_e   state;
    logic [15:0] count;
    logic        last_byte;

    // Read strobe follows the host's ready level while a command is open
    assign ep4_read  = (state == RD_ACTIVE) && ep4_ready;
    assign last_byte = ep4_read && (count == ep4_hdr.length - 16'd1);
    assign done      = (state == RD_DONE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= RD_IDLE;
            count <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (start) begin
                        count <= '0;
                        // Empty command finishes right away
                        if (ep4_hdr.length == 16'd0) begin
                            state <= RD_DONE;
                        end else begin
                            state <= RD_ACTIVE;
                        end
                    end
                end
                RD_ACTIVE: begin
                    if (ep4_read) begin
                        count <= count + 16'd1;
                    end
                    if (last_byte) begin
                        state <= RD_DONE;
                    end
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

    // Bytes beyond the buffer depth are consumed but not kept
    always_ff @(posedge clk) begin
        if (start && state == RD_IDLE) begin
            cmd_bytes <= '0;
        end else if (ep4_read && count < `CMD_MAX_BYTES) begin
            cmd_bytes[count[IDX_BITS-1:0]] <= ep4_data;
        end
    end

endmodule

/* design/ep8_writer.sv */
`timescale 1ns/1ps
`include "cmd_ctrl_macros.svh"

module ep8_writer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     reply_start,
    input  cmd_ctrl_pkg::cmd_hdr_t   reply_hdr,
    input  cmd_ctrl_pkg::cmd_bytes_t reply_bytes,
    input  logic                     ep8_ready,
    output cmd_ctrl_pkg::cmd_hdr_t   ep8_hdr,
    output logic                     ep8_write,
    output logic [7:0]               ep8_data,
    output logic                     reply_done
);
    import cmd_ctrl_pkg::*;

    localparam int IDX_BITS = $clog2(`CMD_MAX_BYTES);

    typedef enum logic {WR_IDLE, WR_SEND} wr_state_e;

    wr_state_e           state;
    logic [15:0]         remaining;
    logic [IDX_BITS-1:0] byte_idx;
    cmd_bytes_t          payload;

    // Highest byte first, down to index 0
    assign byte_idx   = remaining[IDX_BITS-1:0] - 1'b1;
    assign ep8_data   = payload[byte_idx];
    assign ep8_write  = (state == WR_SEND) && ep8_ready && (remaining != 16'd0);
    assign reply_done = (state == WR_SEND) && ep8_ready && (remaining == 16'd0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= WR_IDLE;
            remaining <= '0;
            ep8_hdr   <= '0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (reply_start) begin
                        ep8_hdr   <= reply_hdr;
                        remaining <= reply_hdr.length;
                        state     <= WR_SEND;
                    end
                end
                default: begin
                    if (ep8_write) begin
                        remaining <= remaining - 16'd1;
                    end
                    // Header drops once the host has taken everything
                    if (reply_done) begin
                        ep8_hdr <= '0;
                        state   <= WR_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reply_start && state == WR_IDLE) begin
            payload <= reply_bytes;
        end
    end

endmodule

/* design/cfg_table.sv */
`timescale 1ns/1ps
`include "cmd_ctrl_macros.svh"

module cfg_table (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [7:0]                rd_index,
    output cmd_ctrl_pkg::slot_entry_t rd_entry,
    input  logic                      wr_en,
    input  logic [7:0]                wr_index,
    input  cmd_ctrl_pkg::slot_entry_t wr_entry
);
    // One bank per port, direction and channel-count combination
    localparam int DEPTH = `CFG_PORTS * 4 * `CFG_SLOTS;

    logic [DEPTH-1:0]          used;
    logic [`REG_ADDR_BITS-1:0] tag_mem   [DEPTH];
    logic [7:0]                value_mem [DEPTH];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            used <= '0;
        end else if (wr_en) begin
            used[wr_index] <= wr_entry.used;
        end
    end

    // Registered read
    // A write in the same cycle shows up one access later
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index]   <= wr_entry.addr;
            value_mem[wr_index] <= wr_entry.value;
        end
        rd_entry <= '{
            used:  used[rd_index],
            addr:  tag_mem[rd_index],
            value: value_mem[rd_index]
        };
    end

endmodule

/* design/cfg_access.sv */
`timescale 1ns/1ps
`include "cmd_ctrl_macros.svh"

module cfg_access (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  cmd_ctrl_pkg::cfg_req_t    req,
    output logic                      done,
    output cmd_ctrl_pkg::cfg_result_t result,
    output logic [7:0]                rd_index,
    output logic                      wr_en,
    output logic [7:0]                wr_index,
    output cmd_ctrl_pkg::slot_entry_t wr_entry,
    input  cmd_ctrl_pkg::slot_entry_t rd_entry
);
    import cmd_ctrl_pkg::*;

    localparam int SLOT_BITS = $clog2(`CFG_SLOTS);
    localparam logic [SLOT_BITS-1:0] LAST_SLOT = SLOT_BITS'(`CFG_SLOTS - 1);

    typedef enum logic [1:0] {AC_IDLE, AC_SCAN, AC_WRITE, AC_DONE} ac_state_e;

    ac_state_e            state;
    cfg_req_t             req_q;
    logic [SLOT_BITS-1:0] slot;
    logic [SLOT_BITS-1:0] target;
    logic                 hit;
    logic                 free;

    function automatic logic [7-SLOT_BITS:0] bank_of(cfg_req_t r);
        return {r.port, r.dir, r.chan};
    endfunction

    // Next slot is addressed while the current one is checked
    always_comb begin
        if (state == AC_SCAN) begin
            rd_index = {bank_of(req_q), slot + 1'b1};
        end else begin
            rd_index = {bank_of(req), {SLOT_BITS{1'b0}}};
        end
    end

    assign hit      = rd_entry.used && (rd_entry.addr == req_q.addr);
    assign free     = !rd_entry.used;
    assign done     = (state == AC_DONE);
    assign wr_en    = (state == AC_WRITE);
    assign wr_index = {bank_of(req_q), target};
    assign wr_entry = '{used: 1'b1, addr: req_q.addr, value: req_q.value};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= AC_IDLE;
            slot   <= '0;
            target <= '0;
            result <= '0;
        end else begin
            case (state)
                AC_IDLE: begin
                    if (start) begin
                        slot  <= '0;
                        state <= AC_SCAN;
                    end
                end
                AC_SCAN: begin
                    if (hit && req_q.op == CFG_LOOKUP) begin
                        result <= '{CFG_HIT, rd_entry.value};
                        state  <= AC_DONE;
                    end else if ((hit || free) && req_q.op == CFG_STORE) begin
                        target <= slot;
                        result <= '{CFG_STORED, req_q.value};
                        state  <= AC_WRITE;
                    end else if (free) begin
                        // Slots fill in order, so an unused one ends the search
                        result <= '{CFG_MISS, 8'h00};
                        state  <= AC_DONE;
                    end else if (slot == LAST_SLOT) begin
                        if (req_q.op == CFG_STORE) begin
                            result <= '{CFG_FULL, 8'h00};
                        end else begin
                            result <= '{CFG_MISS, 8'h00};
                        end
                        state <= AC_DONE;
                    end else begin
                        slot <= slot + 1'b1;
                    end
                end
                AC_WRITE: begin
                    state <= AC_DONE;
                end
                default: begin
                    state <= AC_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && state == AC_IDLE) begin
            req_q <= req;
        end
    end

endmodule

/* design/cmd_sequencer.sv */
`timescale 1ns/1ps
`include "cmd_ctrl_macros.svh"

module cmd_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    output logic                      rd_start,
    input  logic                      rd_done,
    input  cmd_ctrl_pkg::cmd_hdr_t    cmd_hdr,
    input  cmd_ctrl_pkg::cmd_bytes_t  cmd_bytes,
    input  logic [`CFG_PORTS-1:0]     direction,
    input  logic [`CFG_PORTS-1:0]     num_channels,
    output logic                      cfg_start,
    output cmd_ctrl_pkg::cfg_req_t    cfg_req,
    input  logic                      cfg_done,
    input  cmd_ctrl_pkg::cfg_result_t cfg_result,
    output logic                      reply_start,
    output cmd_ctrl_pkg::cmd_hdr_t    reply_hdr,
    output cmd_ctrl_pkg::cmd_bytes_t  reply_bytes,
    input  logic                      reply_done
);
    import cmd_ctrl_pkg::*;

    ctrl_state_e                   state;
    logic                          is_set;
    logic                          need_reply;
    logic [$clog2(`CFG_PORTS)-1:0] port;

    assign rd_start = (state == ST_WAITING);

    // Byte 0 carries the port, byte 1 the register, byte 3 the value
    assign port    = cmd_bytes[0][1:0];
    assign cfg_req = '{
        op:    is_set ? CFG_STORE : CFG_LOOKUP,
        port:  port,
        addr:  cmd_bytes[1][`REG_ADDR_BITS-1:0],
        value: cmd_bytes[3],
        dir:   direction[port],
        chan:  num_channels[port]
    };

    // A stored set stays silent
    // A miss or a full bank is reported as not found
    always_comb begin
        reply_hdr   = '0;
        reply_bytes = '0;
        need_reply  = 1'b0;
        if (!is_set && cfg_result.status == CFG_HIT) begin
            need_reply       = 1'b1;
            reply_hdr.id     = OP_DATA_REG;
            reply_hdr.length = 16'd2;
            reply_bytes[0]   = cfg_result.value;
        end else if (cfg_result.status == CFG_MISS || cfg_result.status == CFG_FULL) begin
            need_reply   = 1'b1;
            reply_hdr.id = OP_ERR_NOT_FOUND;
        end
    end

    assign reply_start = (state == ST_EXECUTING) && cfg_done && need_reply;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= ST_WAITING;
            is_set    <= 1'b0;
            cfg_start <= 1'b0;
        end else begin
            cfg_start <= 1'b0;
            case (state)
                ST_WAITING: begin
                    state <= ST_READING;
                end
                ST_READING: begin
                    if (rd_done) begin
                        if (cmd_hdr.id == OP_GET_REG || cmd_hdr.id == OP_SET_REG) begin
                            is_set    <= (cmd_hdr.id == OP_SET_REG);
                            cfg_start <= 1'b1;
                            state     <= ST_EXECUTING;
                        end else begin
                            // Unknown command is dropped after its payload
                            state <= ST_WAITING;
                        end
                    end
                end
                ST_EXECUTING: begin
                    if (cfg_done) begin
                        if (need_reply) begin
                            state <= ST_REPLYING;
                        end else begin
                            state <= ST_WAITING;
                        end
                    end
                end
                default: begin
                    if (reply_done) begin
                        state <= ST_WAITING;
                    end
                end
            endcase
        end
    end

endmodule

/* design/cmd_controller.sv */
`timescale 1ns/1ps
`include "cmd_ctrl_macros.svh"

module cmd_controller (
    input  logic                    clk,
    input  logic                    reset,
    input  cmd_ctrl_pkg::cmd_hdr_t  ep4_hdr,
    input  logic                    ep4_ready,
    input  logic [7:0]              ep4_data,
    output logic                    ep4_read,
    output cmd_ctrl_pkg::cmd_hdr_t  ep8_hdr,
    input  logic                    ep8_ready,
    output logic                    ep8_write,
    output logic [7:0]              ep8_data,
    input  logic [`CFG_PORTS-1:0]   direction,
    input  logic [`CFG_PORTS-1:0]   num_channels
);
    import cmd_ctrl_pkg::*;

    logic        rd_start;
    logic        rd_done;
    cmd_bytes_t  cmd_bytes;
    logic        cfg_start;
    logic        cfg_done;
    cfg_req_t    cfg_req;
    cfg_result_t cfg_result;
    logic        reply_start;
    logic        reply_done;
    cmd_hdr_t    reply_hdr;
    cmd_bytes_t  reply_bytes;
    logic [7:0]  rd_index;
    logic        wr_en;
    logic [7:0]  wr_index;
    slot_entry_t wr_entry;
    slot_entry_t rd_entry;

    ep4_reader u_reader (
        .clk       (clk),
        .reset     (reset),
        .start     (rd_start),
        .ep4_hdr   (ep4_hdr),
        .ep4_ready (ep4_ready),
        .ep4_data  (ep4_data),
        .ep4_read  (ep4_read),
        .done      (rd_done),
        .cmd_bytes (cmd_bytes)
    );

    cmd_sequencer u_sequencer (
        .clk          (clk),
        .reset        (reset),
        .rd_start     (rd_start),
        .rd_done      (rd_done),
        .cmd_hdr      (ep4_hdr),
        .cmd_bytes    (cmd_bytes),
        .direction    (direction),
        .num_channels (num_channels),
        .cfg_start    (cfg_start),
        .cfg_req      (cfg_req),
        .cfg_done     (cfg_done),
        .cfg_result   (cfg_result),
        .reply_start  (reply_start),
        .reply_hdr    (reply_hdr),
        .reply_bytes  (reply_bytes),
        .reply_done   (reply_done)
    );

    cfg_access u_access (
        .clk      (clk),
        .reset    (reset),
        .start    (cfg_start),
        .req      (cfg_req),
        .done     (cfg_done),
        .result   (cfg_result),
        .rd_index (rd_index),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_entry (wr_entry),
        .rd_entry (rd_entry)
    );

    cfg_table u_table (
        .clk      (clk),
        .reset    (reset),
        .rd_index (rd_index),
        .rd_entry (rd_entry),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_entry (wr_entry)
    );

    ep8_writer u_writer (
        .clk         (clk),
        .reset       (reset),
        .reply_start (reply_start),
        .reply_hdr   (reply_hdr),
        .reply_bytes (reply_bytes),
        .ep8_ready   (ep8_ready),
        .ep8_hdr     (ep8_hdr),
        .ep8_write   (ep8_write),
        .ep8_data    (ep8_data),
        .reply_done  (reply_done)
    );

endmodule

/* tb/cmd_controller_sva.sv */
`timescale 1ns/1ps

module cmd_controller_sva (
    input logic                   clk,
    input logic                   reset,
    input logic                   ep4_read,
    input logic                   ep8_write,
    input logic                   ep8_ready,
    input cmd_ctrl_pkg::cmd_hdr_t ep8_hdr
);
    // Only one command is in flight, so reading and replying never overlap
    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        !(ep4_read && ep8_write))
        else $error("ep4_read and ep8_write are high in the same cycle");

    // A byte only goes out while the host is ready and a reply is pending
    a_write_allowed: assert property (@(posedge clk) disable iff (reset)
        ep8_write |-> (ep8_ready && ep8_hdr.id != 8'h00))
        else $error("ep8_write without ep8_ready or with a zero reply id");

    a_quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> (!ep4_read && !ep8_write))
        else $error("endpoint strobe active right after reset");

endmodule

bind cmd_controller cmd_controller_sva u_sva (
    .clk       (clk),
    .reset     (reset),
    .ep4_read  (ep4_read),
    .ep8_write (ep8_write),
    .ep8_ready (ep8_ready),
    .ep8_hdr   (ep8_hdr)
);

/* tb/cmd_controller_tb.sv */
`timescale 1ns/1ps
`include "cmd_ctrl_macros.svh"

module cmd_controller_tb;
    import cmd_ctrl_pkg::*;

    localparam int CYCLES_PER_TEST = 300;
    localparam logic [7:0] OP_UNKNOWN = 8'h55;
    // Nonzero length keeps the reader waiting for a byte between commands
    localparam cmd_hdr_t IDLE_HDR = '{id: 8'h00, length: 16'd1};

    typedef struct packed {
        logic [7:0]            opcode;
        logic [1:0]            port;
        logic [5:0]            addr;
        logic [7:0]            value;
        logic [`CFG_PORTS-1:0] dir;
        logic [`CFG_PORTS-1:0] nch;
        logic                  rand_ready;
        logic [7:0]            exp_id;
        logic [15:0]           exp_len;
        logic [7:0]            exp_value;
    } test_entry_t;

    typedef struct packed {
        cmd_hdr_t    hdr;
        logic [15:0] count;
        logic [15:0] data;
    } reply_t;

    logic                  clk;
    logic                  reset;
    cmd_hdr_t              ep4_hdr;
    logic                  ep4_ready;
    logic [7:0]            ep4_data;
    logic                  ep4_read;
    cmd_hdr_t              ep8_hdr;
    logic                  ep8_ready;
    logic                  ep8_write;
    logic [7:0]            ep8_data;
    logic [`CFG_PORTS-1:0] direction;
    logic [`CFG_PORTS-1:0] num_channels;

    logic        ep4_offer;
    logic        ep4_gate;
    logic        rand_mode;
    logic [31:0] draw;
    integer      seed;
    int          errors;
    int          checks;
    logic        table_built;
    logic        in_reply;
    reply_t      cur_reply;

    test_entry_t tests[$];
    string       names[$];
    reply_t      replies[$];

    // Reference model keeps one entry per stored register and a fill count per bank
    logic [7:0]  model_mem [int];
    int          bank_count [16];

    cmd_controller DUT (
        .clk          (clk),
        .reset        (reset),
        .ep4_hdr      (ep4_hdr),
        .ep4_ready    (ep4_ready),
        .ep4_data     (ep4_data),
        .ep4_read     (ep4_read),
        .ep8_hdr      (ep8_hdr),
        .ep8_ready    (ep8_ready),
        .ep8_write    (ep8_write),
        .ep8_data     (ep8_data),
        .direction    (direction),
        .num_channels (num_channels)
    );

    always #20 clk = ~clk;

    assign ep4_ready = ep4_offer && ep4_gate;

    // Ready levels drop at random only for entries that ask for it
    always @(posedge clk) begin
        #2;
        draw      = $random(seed);
        ep4_gate  = !rand_mode || (draw[1:0] != 2'b00);
        ep8_ready = !rand_mode || (draw[5:4] != 2'b00);
    end

    // EP8 host model samples mid-cycle where everything is settled
    always @(negedge clk) begin
        if (!reset && !in_reply && ep8_hdr.id != 8'h00) begin
            cur_reply = '{hdr: ep8_hdr, count: 16'd0, data: 16'd0};
            in_reply  = 1'b1;
        end
        if (!reset && in_reply && ep8_ready) begin
            if (ep8_write) begin
                cur_reply.count = cur_reply.count + 16'd1;
                cur_reply.data  = {cur_reply.data[7:0], ep8_data};
            end else begin
                replies.push_back(cur_reply);
                in_reply = 1'b0;
            end
        end
    end

    task automatic add_entry(input string name, input logic [7:0] opcode,
                             input logic [1:0] port, input logic [5:0] addr,
                             input logic [7:0] value, input logic [`CFG_PORTS-1:0] dir,
                             input logic [`CFG_PORTS-1:0] nch, input logic rnd);
        test_entry_t e;
        logic [3:0]  bank;
        int          key;
        bank = {port, dir[port], nch[port]};
        key  = bank * 64 + addr;
        e = '{opcode: opcode, port: port, addr: addr, value: value, dir: dir, nch: nch,
              rand_ready: rnd, exp_id: 8'h00, exp_len: 16'd0, exp_value: 8'h00};
        if (opcode == OP_GET_REG) begin
            if (model_mem.exists(key)) begin
                e.exp_id    = OP_DATA_REG;
                e.exp_len   = 16'd2;
                e.exp_value = model_mem[key];
            end else begin
                e.exp_id = OP_ERR_NOT_FOUND;
            end
        end else if (opcode == OP_SET_REG) begin
            if (model_mem.exists(key)) begin
                model_mem[key] = value;
            end else if (bank_count[bank] < `CFG_SLOTS) begin
                model_mem[key]   = value;
                bank_count[bank] = bank_count[bank] + 1;
            end else begin
                e.exp_id = OP_ERR_NOT_FOUND;
            end
        end
        tests.push_back(e);
        names.push_back(name);
    endtask

    task automatic build_tests();
        logic [31:0] r;
        logic [7:0]  op;
        add_entry("get_empty", OP_GET_REG, 2'd1, 6'd5, 8'h00, 4'b0000, 4'b0000, 1'b0);
        add_entry("set_first", OP_SET_REG, 2'd1, 6'd5, 8'hA5, 4'b0000, 4'b0000, 1'b0);
        add_entry("get_after_set", OP_GET_REG, 2'd1, 6'd5, 8'h00, 4'b0000, 4'b0000, 1'b0);
        add_entry("set_overwrite", OP_SET_REG, 2'd1, 6'd5, 8'h3C, 4'b0000, 4'b0000, 1'b0);
        add_entry("get_overwrite", OP_GET_REG, 2'd1, 6'd5, 8'h00, 4'b0000, 4'b0000, 1'b0);
        add_entry("get_other_dir", OP_GET_REG, 2'd1, 6'd5, 8'h00, 4'b0010, 4'b0000, 1'b0);
        add_entry("get_other_chan", OP_GET_REG, 2'd1, 6'd5, 8'h00, 4'b0000, 4'b0010, 1'b0);
        // Bits of the other ports do not change the bank
        add_entry("get_other_bits", OP_GET_REG, 2'd1, 6'd5, 8'h00, 4'b1101, 4'b1101, 1'b0);
        for (int i = 0; i < `CFG_SLOTS; i++) begin
            add_entry($sformatf("fill_set_%0d", i), OP_SET_REG, 2'd2, 6'(16 + i),
                      8'(8'h40 + i), 4'b0100, 4'b0000, 1'b0);
        end
        add_entry("set_bank_full", OP_SET_REG, 2'd2, 6'd50, 8'h77, 4'b0100, 4'b0000, 1'b0);
        add_entry("get_full_miss", OP_GET_REG, 2'd2, 6'd50, 8'h00, 4'b0100, 4'b0000, 1'b0);
        for (int i = 0; i < `CFG_SLOTS; i++) begin
            add_entry($sformatf("fill_get_%0d", i), OP_GET_REG, 2'd2, 6'(16 + i),
                      8'h00, 4'b0100, 4'b0000, 1'b0);
        end
        add_entry("unknown_op", OP_UNKNOWN, 2'd1, 6'd5, 8'h11, 4'b0000, 4'b0000, 1'b0);
        add_entry("get_after_unknown", OP_GET_REG, 2'd1, 6'd5, 8'h00, 4'b0000, 4'b0000, 1'b0);
        // Mixed commands on port 3 with both ready levels toggling
        for (int i = 0; i < 12; i++) begin
            r  = $random(seed);
            op = (i % 3 == 0) ? OP_SET_REG : (i % 3 == 1) ? OP_GET_REG : OP_UNKNOWN;
            add_entry($sformatf("rand_%0d", i), op, 2'd3, 6'(r[1:0]), r[15:8],
                      4'b0000, 4'b0000, 1'b1);
        end
        add_entry("rand_final_get", OP_GET_REG, 2'd1, 6'd5, 8'h00, 4'b0000, 4'b0000, 1'b1);
    endtask

    // EP4 host model offers one command and holds its header until the reader is done
    task automatic send_command(input test_entry_t t);
        logic [7:0] payload [4];
        int         len;
        int         idx;
        logic       took;
        payload[0] = {6'd0, t.port};
        payload[1] = {2'd0, t.addr};
        payload[2] = 8'h00;
        payload[3] = t.value;
        len = (t.opcode == OP_GET_REG) ? 2 : (t.opcode == OP_SET_REG) ? 4 : 3;
        rand_mode = t.rand_ready;
        ep4_hdr   = '{id: t.opcode, length: 16'(len)};
        ep4_data  = payload[0];
        ep4_offer = 1'b1;
        idx = 0;
        while (idx < len) begin
            @(negedge clk);
            took = ep4_read;
            @(posedge clk);
            #2;
            if (took) begin
                // Previous command has fully finished once this one is being read
                if (idx == 0) begin
                    direction    = t.dir;
                    num_channels = t.nch;
                end
                idx = idx + 1;
                if (idx < len) begin
                    ep4_data = payload[idx];
                end
            end
        end
        ep4_offer = 1'b0;
        // The opcode is decoded from the header one cycle after the last byte
        @(posedge clk);
        #2;
    endtask

    task automatic check_field(input string name, input string what,
                               input logic [15:0] expected, input logic [15:0] actual);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("mismatch %s %s: expected %h, actual %h", name, what, expected, actual);
        end
    endtask

    task automatic run_test(input int i);
        test_entry_t t;
        reply_t      got;
        t = tests[i];
        send_command(t);
        // Any reply of an earlier silent command ends before this command is read
        while (replies.size() != 0) begin
            got    = replies.pop_front();
            errors = errors + 1;
            $display("a reply with id %h came for a command that needs none, before %s",
                     got.hdr.id, names[i]);
        end
        if (t.exp_id != 8'h00) begin
            while (replies.size() == 0) begin
                @(posedge clk);
                #2;
            end
            got = replies.pop_front();
            check_field(names[i], "reply id", {8'h00, t.exp_id}, {8'h00, got.hdr.id});
            check_field(names[i], "reply length", t.exp_len, got.hdr.length);
            check_field(names[i], "bytes written", t.exp_len, got.count);
            if (t.exp_len == 16'd2) begin
                check_field(names[i], "reply data", {8'h00, t.exp_value}, got.data);
            end
        end
    endtask

    task automatic report_and_finish();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        ep4_hdr      = IDLE_HDR;
        ep4_data     = 8'h00;
        ep4_offer    = 1'b0;
        ep4_gate     = 1'b1;
        ep8_ready    = 1'b1;
        direction    = '0;
        num_channels = '0;
        rand_mode    = 1'b0;
        in_reply     = 1'b0;
        errors       = 0;
        checks       = 0;
        seed         = 29692;
        table_built  = 1'b0;
        build_tests();
        table_built = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int i = 0; i < tests.size(); i++) begin
            run_test(i);
        end
        report_and_finish();
    end

    initial begin
        wait (table_built);
        repeat (tests.size() * CYCLES_PER_TEST + 20) @(posedge clk);
        errors = errors + 1;
        $display("timeout: the tests did not finish within %0d cycles",
                 tests.size() * CYCLES_PER_TEST + 20);
        report_and_finish();
    end

endmodule

/* compile.f */
+incdir+design
design/cmd_ctrl_pkg.sv
design/ep4_reader.sv
design/ep8_writer.sv
design/cfg_table.sv
design/cfg_access.sv
design/cmd_sequencer.sv
design/cmd_controller.sv
tb/cmd_controller_sva.sv
tb/cmd_controller_tb.sv

/* Bender.yml */
package:
  name: cmd_controller

export_include_dirs:
  - design

sources:
  - files:
      - design/cmd_ctrl_pkg.sv
      - design/ep4_reader.sv
      - design/ep8_writer.sv
      - design/cfg_table.sv
      - design/cfg_access.sv
      - design/cmd_sequencer.sv
      - design/cmd_controller.sv
  - target: test
    files:
      - tb/cmd_controller_sva.sv
      - tb/cmd_controller_tb.sv
